//--- hw/rtcBusPkg.sv
package rtcBusPkg;

    // Shared address/data bus
    localparam int busWidth = 8;

    // Register address bits decoded by the RTC
    localparam int regAddrWidth = 7;

    typedef logic [busWidth-1:0] busWord;

    // Strobe low time in clock cycles
    localparam int defaultPulseWidth = 6;

    // Address write strobe always starts one count into the frame
    localparam int addrStrobeStart = 2;

    // Frame windows as a function of the strobe width p
    function automatic int addrPhaseEnd(int p);
        return p + 2;
    endfunction

    function automatic int addrStrobeEnd(int p);
        return p + 1;
    endfunction

    function automatic int dataPhaseStart(int p);
        return 3 * p + 2;
    endfunction

    function automatic int dataPhaseEnd(int p);
        return 4 * p + 3;
    endfunction

    // Data strobe sits one count inside the data window on both sides
    function automatic int dataStrobeStart(int p);
        return dataPhaseStart(p) + 1;
    endfunction

    function automatic int dataStrobeEnd(int p);
        return dataPhaseEnd(p) - 1;
    endfunction

    function automatic int frameLength(int p);
        return 6 * p + 1;
    endfunction

endpackage

//--- hw/rtcCommandLatch.sv
module rtcCommandLatch (
    input  logic               clk,
    input  logic               reset,
    input  logic               cmdValid,
    input  logic               cmdRead,
    input  rtcBusPkg::busWord  cmdAddr,
    input  rtcBusPkg::busWord  cmdWriteData,
    input  logic               frameEnd,
    output logic               start,
    output logic               frameRead,
    output logic               busy,
    output rtcBusPkg::busWord  heldAddr,
    output rtcBusPkg::busWord  heldData
);

    logic accept;

    // Only an idle controller takes a command, anything else is dropped
    assign accept = cmdValid && !busy;

    // Control state
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy      <= 1'b0;
            start     <= 1'b0;
            frameRead <= 1'b0;
        end
        else
        begin
            start <= accept;
            if (accept)
            begin
                busy      <= 1'b1;
                frameRead <= cmdRead;
            end
            else if (frameEnd)
            begin
                busy <= 1'b0;
            end
        end
    end

    // Command payload, held until the next accepted command
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            // RTC decodes only the low address bits
            heldAddr <= rtcBusPkg::busWord'(cmdAddr[rtcBusPkg::regAddrWidth-1:0]);
            heldData <= cmdWriteData;
        end
    end

    // start follows a real acceptance and busy is already up by then
    startOnlyFromIdle: assert property (
        @(posedge clk) disable iff (reset)
        start |-> !$past(busy) && busy
    ) else $error("start without an idle acceptance");

endmodule

//--- hw/rtcCycleTimer.sv
module rtcCycleTimer #(
    parameter int pulseWidth = rtcBusPkg::defaultPulseWidth
) (
    input  logic clk,
    input  logic reset,
    input  logic start,
    input  logic frameRead,
    output logic chipSelectN,
    output logic readN,
    output logic writeN,
    output logic addrOrData,
    output logic addrPhase,
    output logic dataPhase,
    output logic sampleNow,
    output logic frameEnd
);

    localparam int frameLen   = rtcBusPkg::frameLength(pulseWidth);
    localparam int countWidth = $clog2(frameLen + 1);

    localparam logic [countWidth-1:0] firstCount = countWidth'(1);
    localparam logic [countWidth-1:0] lastCount  = countWidth'(frameLen);

    // Window edges in count units
    localparam logic [countWidth-1:0] addrEnd =
        countWidth'(rtcBusPkg::addrPhaseEnd(pulseWidth));
    localparam logic [countWidth-1:0] addrStrobeFirst =
        countWidth'(rtcBusPkg::addrStrobeStart);
    localparam logic [countWidth-1:0] addrStrobeLast =
        countWidth'(rtcBusPkg::addrStrobeEnd(pulseWidth));
    localparam logic [countWidth-1:0] dataStart =
        countWidth'(rtcBusPkg::dataPhaseStart(pulseWidth));
    localparam logic [countWidth-1:0] dataEnd =
        countWidth'(rtcBusPkg::dataPhaseEnd(pulseWidth));
    localparam logic [countWidth-1:0] dataStrobeFirst =
        countWidth'(rtcBusPkg::dataStrobeStart(pulseWidth));
    localparam logic [countWidth-1:0] dataStrobeLast =
        countWidth'(rtcBusPkg::dataStrobeEnd(pulseWidth));

    logic [countWidth-1:0] count;
    logic                  inAddrWin;
    logic                  inDataWin;
    logic                  inAddrStrobe;
    logic                  inDataStrobe;

    // Frame counter, zero means idle
    always_ff @(posedge clk)
    begin
        if (reset)
            count <= '0;
        else if (start)
            count <= firstCount;
        else if (count == lastCount)
            count <= '0;
        else if (count != '0)
            count <= count + 1'b1;
    end

    assign frameEnd = (count == lastCount);

    // Window decode
    always_comb
    begin
        inAddrWin    = (count >= firstCount) && (count <= addrEnd);
        inDataWin    = (count >= dataStart) && (count <= dataEnd);
        inAddrStrobe = (count >= addrStrobeFirst) && (count <= addrStrobeLast);
        inDataStrobe = (count >= dataStrobeFirst) && (count <= dataStrobeLast);
    end

    // Strobes lag the count by one cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            chipSelectN <= 1'b1;
            addrOrData  <= 1'b1;
            writeN      <= 1'b1;
            readN       <= 1'b1;
            addrPhase   <= 1'b0;
            dataPhase   <= 1'b0;
            sampleNow   <= 1'b0;
        end
        else
        begin
            chipSelectN <= !(inAddrWin || inDataWin);
            addrOrData  <= !inAddrWin;
            // Address is always written, data only in a write frame
            writeN      <= !(inAddrStrobe || (inDataStrobe && !frameRead));
            readN       <= !(inDataStrobe && frameRead);
            addrPhase   <= inAddrWin;
            dataPhase   <= inDataWin;
            // Lands in the last low cycle of readN
            sampleNow   <= frameRead && (count == dataStrobeLast);
        end
    end

    strobesExclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(!readN && !writeN)
    ) else $error("readN and writeN low together");

    strobesInsideSelect: assert property (
        @(posedge clk) disable iff (reset)
        (!readN || !writeN) |-> !chipSelectN
    ) else $error("strobe active with chip deselected");

endmodule

//--- hw/rtcBusDriver.sv
module rtcBusDriver (
    input  logic               clk,
    input  logic               reset,
    input  logic               addrPhase,
    input  logic               dataPhase,
    input  logic               frameRead,
    input  logic               sampleNow,
    input  logic               frameEnd,
    input  rtcBusPkg::busWord  heldAddr,
    input  rtcBusPkg::busWord  heldData,
    input  rtcBusPkg::busWord  busIn,
    output rtcBusPkg::busWord  busOut,
    output logic               busOe,
    output rtcBusPkg::busWord  readData,
    output logic               done
);

    logic driveNext;

    // Chip owns the bus in the data phase of a read
    assign driveNext = addrPhase || (dataPhase && !frameRead);

    // Pad enable and completion pulse
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busOe <= 1'b0;
            done  <= 1'b0;
        end
        else
        begin
            busOe <= driveNext;
            done  <= frameEnd;
        end
    end

    // Bus byte: address first, then write data
    always_ff @(posedge clk)
    begin
        if (addrPhase)
            busOut <= heldAddr;
        else
            busOut <= heldData;
    end

    // Read byte stays until the next read captures over it
    always_ff @(posedge clk)
    begin
        if (reset)
            readData <= '0;
        else if (sampleNow)
            readData <= busIn;
    end

    // No bus fight while the RTC drives read data
    noDriveOnReadData: assert property (
        @(posedge clk) disable iff (reset)
        dataPhase && frameRead |-> !busOe
    ) else $error("busOe high during read data phase");

endmodule

//--- hw/rtcBusTop.sv
module rtcBusTop #(
    parameter int pulseWidth = rtcBusPkg::defaultPulseWidth
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               cmdValid,
    input  logic               cmdRead,
    input  rtcBusPkg::busWord  cmdAddr,
    input  rtcBusPkg::busWord  cmdWriteData,
    input  rtcBusPkg::busWord  busIn,
    output logic               busy,
    output logic               done,
    output rtcBusPkg::busWord  readData,
    output logic               chipSelectN,
    output logic               readN,
    output logic               writeN,
    output logic               addrOrData,
    output rtcBusPkg::busWord  busOut,
    output logic               busOe
);

    logic              start;
    logic              frameRead;
    logic              frameEnd;
    logic              addrPhase;
    logic              dataPhase;
    logic              sampleNow;
    rtcBusPkg::busWord heldAddr;
    rtcBusPkg::busWord heldData;

    rtcCommandLatch i_rtcCommandLatch (
        .clk          (clk),
        .reset        (reset),
        .cmdValid     (cmdValid),
        .cmdRead      (cmdRead),
        .cmdAddr      (cmdAddr),
        .cmdWriteData (cmdWriteData),
        .frameEnd     (frameEnd),
        .start        (start),
        .frameRead    (frameRead),
        .busy         (busy),
        .heldAddr     (heldAddr),
        .heldData     (heldData)
    );

    rtcCycleTimer #(
        .pulseWidth (pulseWidth)
    ) i_rtcCycleTimer (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .frameRead   (frameRead),
        .chipSelectN (chipSelectN),
        .readN       (readN),
        .writeN      (writeN),
        .addrOrData  (addrOrData),
        .addrPhase   (addrPhase),
        .dataPhase   (dataPhase),
        .sampleNow   (sampleNow),
        .frameEnd    (frameEnd)
    );

    rtcBusDriver i_rtcBusDriver (
        .clk       (clk),
        .reset     (reset),
        .addrPhase (addrPhase),
        .dataPhase (dataPhase),
        .frameRead (frameRead),
        .sampleNow (sampleNow),
        .frameEnd  (frameEnd),
        .heldAddr  (heldAddr),
        .heldData  (heldData),
        .busIn     (busIn),
        .busOut    (busOut),
        .busOe     (busOe),
        .readData  (readData),
        .done      (done)
    );

endmodule

//--- verif/rtcDeviceModel.sv
module rtcDeviceModel (
    input  logic              chipSelectN,
    input  logic              readN,
    input  logic              writeN,
    input  logic              addrOrData,
    input  logic              busOe,
    input  rtcBusPkg::busWord busOut,
    output rtcBusPkg::busWord busIn
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int regCount = 1 << rtcBusPkg::regAddrWidth;

    rtcBusPkg::busWord                  regFile [regCount];
    logic [rtcBusPkg::regAddrWidth-1:0] addrReg;

    // Power-up contents, distinct for every address
    initial
    begin
        addrReg = '0;
        for (int i = 0; i < regCount; i++)
            regFile[i] = rtcBusPkg::busWord'(i * 37 + 11);
    end

    // Chip takes the bus byte when writeN rises
    always @(posedge writeN)
    begin
        if (!chipSelectN && busOe)
        begin
            if (!addrOrData)
                addrReg <= busOut[rtcBusPkg::regAddrWidth-1:0];
            else
                regFile[addrReg] <= busOut;
        end
    end

    // Bus floats high when the chip is not driving
    assign busIn = (!readN && !chipSelectN) ? regFile[addrReg] : 8'hFF;

endmodule

//--- verif/rtcBusTb.sv
module rtcBusTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int pulseWidth    = rtcBusPkg::defaultPulseWidth;
    localparam int frameLen      = rtcBusPkg::frameLength(pulseWidth);
    localparam int regCount      = 1 << rtcBusPkg::regAddrWidth;
    localparam int timeoutCycles = 100;

    // Address bits the RTC decodes
    localparam rtcBusPkg::busWord addrMask = rtcBusPkg::busWord'(regCount - 1);

    logic              clk = 1'b0;
    logic              reset;
    logic              cmdValid;
    logic              cmdRead;
    rtcBusPkg::busWord cmdAddr;
    rtcBusPkg::busWord cmdWriteData;
    rtcBusPkg::busWord busIn;
    logic              busy;
    logic              done;
    rtcBusPkg::busWord readData;
    logic              chipSelectN;
    logic              readN;
    logic              writeN;
    logic              addrOrData;
    rtcBusPkg::busWord busOut;
    logic              busOe;

    int                mismatches;
    int                timeouts;
    logic [31:0]       rngState;
    rtcBusPkg::busWord scoreboard [regCount];

    rtcBusTop #(.pulseWidth(pulseWidth)) i_rtcBusTop (
        .clk(clk), .reset(reset), .cmdValid(cmdValid), .cmdRead(cmdRead),
        .cmdAddr(cmdAddr), .cmdWriteData(cmdWriteData), .busIn(busIn),
        .busy(busy), .done(done), .readData(readData), .chipSelectN(chipSelectN),
        .readN(readN), .writeN(writeN), .addrOrData(addrOrData),
        .busOut(busOut), .busOe(busOe)
    );

    rtcDeviceModel i_rtcDeviceModel (
        .chipSelectN(chipSelectN), .readN(readN), .writeN(writeN),
        .addrOrData(addrOrData), .busOe(busOe), .busOut(busOut), .busIn(busIn)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] s;
        s = state ^ (state << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    // Strobe windows k cycles after acceptance, one cycle behind the count
    function automatic logic inAddrStrobe(input int k);
        return (k - 1 >= 2) && (k - 1 <= pulseWidth + 1);
    endfunction

    function automatic logic inDataStrobe(input int k);
        return (k - 1 >= rtcBusPkg::dataPhaseStart(pulseWidth) + 1) &&
               (k - 1 <= rtcBusPkg::dataPhaseEnd(pulseWidth) - 1);
    endfunction

    task automatic compareByte(input string name, input rtcBusPkg::busWord got,
                               input rtcBusPkg::busWord expected);
        if (got !== expected)
        begin
            mismatches++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic compareBit(input string name, input logic got, input logic expected);
        if (got !== expected)
        begin
            mismatches++;
            $display("ERROR at %0t ns: %s is %b, expected %b", $time, name, got, expected);
        end
    endtask

    task automatic endRun();
        $display("Errors: %0d mismatches, %0d timeouts", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    endtask

    // Issue one command and follow its frame until done, checking strobes each cycle
    task automatic runFrame(input logic isRead, input rtcBusPkg::busWord addr,
                            input rtcBusPkg::busWord data, input int extraCmdAt);
        int k;
        cmdValid     = 1'b1;
        cmdRead      = isRead;
        cmdAddr      = addr;
        cmdWriteData = data;
        @(negedge clk);
        cmdValid = 1'b0;
        compareBit("busy", busy, 1'b1);
        k = 0;
        while (!done)
        begin
            @(negedge clk);
            k++;
            if (k > timeoutCycles)
            begin
                $display("Timeout: no done within %0d cycles of a command", timeoutCycles);
                timeouts++;
                endRun();
            end
            else
            begin
                // Second command while busy, must be dropped
                cmdValid = (k == extraCmdAt);
                cmdRead  = 1'b0;
                cmdWriteData = ~data;
                compareBit("writeN", writeN, !(inAddrStrobe(k) || (inDataStrobe(k) && !isRead)));
                compareBit("readN", readN, !(inDataStrobe(k) && isRead));
                // Bus contents while a strobe is low
                if (inAddrStrobe(k))
                begin
                    compareBit("chipSelectN", chipSelectN, 1'b0);
                    compareBit("addrOrData", addrOrData, 1'b0);
                    compareBit("busOe", busOe, 1'b1);
                    compareByte("busOut", busOut & addrMask, addr & addrMask);
                end
                else if (inDataStrobe(k))
                begin
                    compareBit("chipSelectN", chipSelectN, 1'b0);
                    compareBit("addrOrData", addrOrData, 1'b1);
                    compareBit("busOe", busOe, !isRead);
                    if (!isRead)
                        compareByte("busOut", busOut, data);
                end
            end
        end
        if (k != frameLen + 1)
        begin
            mismatches++;
            $display("ERROR at %0t ns: done came %0d cycles after acceptance, expected %0d",
                     $time, k, frameLen + 1);
        end
    endtask

    task automatic writeReg(input rtcBusPkg::busWord addr, input rtcBusPkg::busWord data);
        runFrame(1'b0, addr, data, -1);
        scoreboard[addr[rtcBusPkg::regAddrWidth-1:0]] = data;
    endtask

    task automatic readReg(input rtcBusPkg::busWord addr, input rtcBusPkg::busWord expected);
        runFrame(1'b1, addr, 8'h00, -1);
        compareByte("readData", readData, expected);
    endtask

    task automatic checkResetState();
        compareBit("chipSelectN", chipSelectN, 1'b1);
        compareBit("readN", readN, 1'b1);
        compareBit("writeN", writeN, 1'b1);
        compareBit("addrOrData", addrOrData, 1'b1);
        compareBit("busOe", busOe, 1'b0);
        compareBit("busy", busy, 1'b0);
        compareBit("done", done, 1'b0);
        compareByte("readData", readData, 8'h00);
    endtask

    task automatic writeThenRead();
        writeReg(8'h15, 8'hA7);
        readReg(8'h15, 8'hA7);
    endtask

    task automatic randomPairs();
        rtcBusPkg::busWord addr;
        for (int n = 0; n < 10; n++)
        begin
            rngState = xorshift(rngState);
            addr     = rngState[7:0];
            writeReg(addr, rngState[15:8]);
            readReg(addr, scoreboard[addr[rtcBusPkg::regAddrWidth-1:0]]);
        end
    endtask

    task automatic droppedWhileBusy();
        runFrame(1'b0, 8'h42, 8'h3C, 5);
        scoreboard[7'h42] = 8'h3C;
        // A dropped command must not start a second frame
        for (int i = 0; i < frameLen + 2; i++)
        begin
            @(negedge clk);
            compareBit("busy", busy, 1'b0);
            compareBit("done", done, 1'b0);
        end
        readReg(8'h42, 8'h3C);
    endtask

    initial
    begin
        reset        = 1'b1;
        cmdValid     = 1'b0;
        cmdRead      = 1'b0;
        cmdAddr      = '0;
        cmdWriteData = '0;
        mismatches   = 0;
        timeouts     = 0;
        rngState     = 32'd73;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        checkResetState();
        writeThenRead();
        randomPairs();
        droppedWhileBusy();
        endRun();
    end

endmodule

//--- tb.f
hw/rtcBusPkg.sv
hw/rtcCommandLatch.sv
hw/rtcCycleTimer.sv
hw/rtcBusDriver.sv
hw/rtcBusTop.sv
verif/rtcDeviceModel.sv
verif/rtcBusTb.sv

//--- Makefile
SOURCES = $(wildcard hw/*.sv verif/*.sv)

.PHONY: run clean

obj_dir/VrtcBusTb: tb.f $(SOURCES)
	verilator --binary --timing --assert --top-module rtcBusTb -f tb.f

run: obj_dir/VrtcBusTb
	@out=$$(./obj_dir/VrtcBusTb); echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
